//--- ddr_port_mux.f
hdl/ddr_cache_pkg.sv
hdl/ddr_bus_pkg.sv
hdl/port_line_cache.sv
hdl/ddr_scheduler.sv
hdl/ddr_port_mux.sv
tests/ddr_mem_model.sv
tests/ddr_port_mux_tb.sv

//--- hdl/ddr_bus_pkg.sv
// DDR bus side definitions: widths, burst counts, base region and scheduler states
`default_nettype none

package ddr_bus_pkg;

	// bus widths
	localparam int ddr_data_w  = 64;
	localparam int ddr_be_w    = ddr_data_w / 8;
	localparam int ddr_addr_w  = 29;
	localparam int ddr_burst_w = 8;

	// fixed upper address bits, region starts at 0x30000000
	localparam logic [3:0] ddr_base_bits = 4'd3;

	// 64-bit word address below the base bits
	localparam int ddr_word_w = ddr_addr_w - $bits(ddr_base_bits);

	// refill is two beats, each flush half goes out alone
	localparam logic [ddr_burst_w-1:0] rd_burst = 8'd2;
	localparam logic [ddr_burst_w-1:0] wr_burst = 8'd1;

	// scheduler sequencer
	typedef enum logic [1:0] {
		sched_idle,
		sched_wr_ack,
		sched_rd_hi,
		sched_rd_lo
	} sched_state_e;

endpackage

`default_nettype wire

//--- hdl/ddr_cache_pkg.sv
// client-side geometry of the port caches: address, data, lane and line widths
`default_nettype none

package ddr_cache_pkg;

	// client halfword address, bits port_addr_w down to 1
	localparam int port_addr_w = 27;

	// client data bus and its byte lanes
	localparam int port_data_w = 32;
	localparam int port_lane_w = 4;

	// one cache line
	localparam int line_bytes = 16;
	localparam int line_w     = line_bytes * 8;

	// line address, the port address without the in-line halfword bits
	localparam int half_sel_w = 3;
	localparam int tag_w      = port_addr_w - half_sel_w;

	// word index inside a line
	// upper bits of the halfword index
	localparam int word_sel_w = 2;

endpackage

`default_nettype wire

//--- hdl/ddr_port_mux.sv
// multi-port DDR front end: one line cache per client port and a shared scheduler
`timescale 1ns/1ps
`default_nettype none

module ddr_port_mux #(
	parameter int num_ports = 3
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	// client ports
	input  logic [ddr_cache_pkg::port_addr_w:1]     addr [num_ports],
	input  logic [ddr_cache_pkg::port_data_w-1:0]   din [num_ports],
	input  logic [num_ports-1:0]                    rd,
	input  logic [ddr_cache_pkg::port_lane_w-1:0]   wr [num_ports],
	input  logic [num_ports-1:0]                    mode16,
	output logic [ddr_cache_pkg::port_data_w-1:0]   dout [num_ports],
	output logic [num_ports-1:0]                    busy,
	// DDR bus
	input  logic                                    ddr_busy,
	input  logic [ddr_bus_pkg::ddr_data_w-1:0]      ddr_dout,
	input  logic                                    ddr_dout_ready,
	output logic                                    ddr_rd,
	output logic                                    ddr_we,
	output logic [ddr_bus_pkg::ddr_addr_w-1:0]      ddr_addr,
	output logic [ddr_bus_pkg::ddr_data_w-1:0]      ddr_din,
	output logic [ddr_bus_pkg::ddr_be_w-1:0]        ddr_be,
	output logic [ddr_bus_pkg::ddr_burst_w-1:0]     ddr_burstcnt
);

// cache to scheduler
wire [num_ports-1:0] rd_pend;
wire [ddr_cache_pkg::tag_w-1:0] rd_tag [num_ports];
wire [num_ports-1:0] wr_pend;
wire [ddr_bus_pkg::ddr_word_w-1:0] wr_addr [num_ports];
wire [ddr_bus_pkg::ddr_data_w-1:0] wr_data [num_ports];
wire [ddr_bus_pkg::ddr_be_w-1:0] wr_be [num_ports];

// scheduler to cache
wire [num_ports-1:0] wr_done;
wire [num_ports-1:0] fill_valid;
wire [num_ports-1:0] fill_hi;
wire [ddr_bus_pkg::ddr_data_w-1:0] fill_data;

for (genvar i = 0; i < num_ports; i++) begin : g_port
	port_line_cache port_line_cache_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (addr[i]),
		.din        (din[i]),
		.rd         (rd[i]),
		.wr         (wr[i]),
		.mode16     (mode16[i]),
		.dout       (dout[i]),
		.busy       (busy[i]),
		.rd_pend    (rd_pend[i]),
		.rd_tag     (rd_tag[i]),
		.wr_pend    (wr_pend[i]),
		.wr_addr    (wr_addr[i]),
		.wr_data    (wr_data[i]),
		.wr_be      (wr_be[i]),
		.wr_done    (wr_done[i]),
		.fill_valid (fill_valid[i]),
		.fill_hi    (fill_hi[i]),
		.fill_data  (fill_data)
	);
end

ddr_scheduler #(
	.num_ports (num_ports)
) ddr_scheduler_inst (
	.clk            (clk),
	.rst_n          (rst_n),
	.rd_pend        (rd_pend),
	.rd_tag         (rd_tag),
	.wr_pend        (wr_pend),
	.wr_addr        (wr_addr),
	.wr_data        (wr_data),
	.wr_be          (wr_be),
	.wr_done        (wr_done),
	.fill_valid     (fill_valid),
	.fill_hi        (fill_hi),
	.fill_data      (fill_data),
	.ddr_busy       (ddr_busy),
	.ddr_dout       (ddr_dout),
	.ddr_dout_ready (ddr_dout_ready),
	.ddr_rd         (ddr_rd),
	.ddr_we         (ddr_we),
	.ddr_addr       (ddr_addr),
	.ddr_din        (ddr_din),
	.ddr_be         (ddr_be),
	.ddr_burstcnt   (ddr_burstcnt)
);

endmodule

`default_nettype wire

//--- hdl/ddr_scheduler.sv
// fixed-priority DDR scheduler: picks a port, issues its command and routes refill beats
`timescale 1ns/1ps
`default_nettype none

module ddr_scheduler #(
	parameter int num_ports = 3
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	// port requests
	input  logic [num_ports-1:0]                    rd_pend,
	input  logic [ddr_bus_pkg::ddr_word_w-2:0]      rd_tag [num_ports],
	input  logic [num_ports-1:0]                    wr_pend,
	input  logic [ddr_bus_pkg::ddr_word_w-1:0]      wr_addr [num_ports],
	input  logic [ddr_bus_pkg::ddr_data_w-1:0]      wr_data [num_ports],
	input  logic [ddr_bus_pkg::ddr_be_w-1:0]        wr_be [num_ports],
	// strobes back to the selected port
	output logic [num_ports-1:0]                    wr_done,
	output logic [num_ports-1:0]                    fill_valid,
	output logic [num_ports-1:0]                    fill_hi,
	output logic [ddr_bus_pkg::ddr_data_w-1:0]      fill_data,
	// DDR bus
	input  logic                                    ddr_busy,
	input  logic [ddr_bus_pkg::ddr_data_w-1:0]      ddr_dout,
	input  logic                                    ddr_dout_ready,
	output logic                                    ddr_rd,
	output logic                                    ddr_we,
	output logic [ddr_bus_pkg::ddr_addr_w-1:0]      ddr_addr,
	output logic [ddr_bus_pkg::ddr_data_w-1:0]      ddr_din,
	output logic [ddr_bus_pkg::ddr_be_w-1:0]        ddr_be,
	output logic [ddr_bus_pkg::ddr_burst_w-1:0]     ddr_burstcnt
);

localparam int sel_w = (num_ports > 1) ? $clog2(num_ports) : 1;

ddr_bus_pkg::sched_state_e state;
// port being served
logic [sel_w-1:0] sel;
logic [sel_w-1:0] pick;
logic pick_any;
logic pick_wr;
logic ack_now;
logic beat_now;

// lowest index wins, its write before its read
always_comb begin
	pick = '0;
	pick_wr = 1'b0;
	for (int i = num_ports - 1; i >= 0; i--) begin
		if (wr_pend[i] || rd_pend[i]) begin
			pick = sel_w'(i);
			pick_wr = wr_pend[i];
		end
	end
end
assign pick_any = |(wr_pend | rd_pend);

// nothing moves on a busy cycle
// the slave keeps a beat on the bus until a non-busy cycle
assign ack_now = !ddr_busy && state == ddr_bus_pkg::sched_wr_ack;
assign beat_now = !ddr_busy && ddr_dout_ready &&
	(state == ddr_bus_pkg::sched_rd_hi || state == ddr_bus_pkg::sched_rd_lo);

always_comb begin
	for (int i = 0; i < num_ports; i++) begin
		wr_done[i] = ack_now && sel == sel_w'(i);
		fill_valid[i] = beat_now && sel == sel_w'(i);
		fill_hi[i] = beat_now && sel == sel_w'(i) && state == ddr_bus_pkg::sched_rd_hi;
	end
end
// beats go to every port, only the strobed one takes them
assign fill_data = ddr_dout;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= ddr_bus_pkg::sched_idle;
		sel <= '0;
		ddr_rd <= 1'b0;
		ddr_we <= 1'b0;
	end else if (!ddr_busy) begin
		// command lives for one non-busy cycle
		ddr_rd <= 1'b0;
		ddr_we <= 1'b0;
		case (state)
			ddr_bus_pkg::sched_idle: begin
				if (pick_any) begin
					sel <= pick;
					if (pick_wr) begin
						ddr_we <= 1'b1;
						state <= ddr_bus_pkg::sched_wr_ack;
					end else begin
						ddr_rd <= 1'b1;
						state <= ddr_bus_pkg::sched_rd_hi;
					end
				end
			end
			ddr_bus_pkg::sched_wr_ack: state <= ddr_bus_pkg::sched_idle;
			// upper 64 bits come first
			ddr_bus_pkg::sched_rd_hi: if (ddr_dout_ready) state <= ddr_bus_pkg::sched_rd_lo;
			ddr_bus_pkg::sched_rd_lo: if (ddr_dout_ready) state <= ddr_bus_pkg::sched_idle;
			default: state <= ddr_bus_pkg::sched_idle;
		endcase
	end
end

// command payload
always_ff @(posedge clk) begin
	if (!ddr_busy && state == ddr_bus_pkg::sched_idle && pick_any) begin
		if (pick_wr) begin
			ddr_addr <= {ddr_bus_pkg::ddr_base_bits, wr_addr[pick]};
			ddr_din <= wr_data[pick];
			ddr_be <= wr_be[pick];
			ddr_burstcnt <= ddr_bus_pkg::wr_burst;
		end else begin
			// refill always starts at the upper half of the line
			ddr_addr <= {ddr_bus_pkg::ddr_base_bits, rd_tag[pick], 1'b0};
			ddr_be <= '1;
			ddr_burstcnt <= ddr_bus_pkg::rd_burst;
		end
	end
end

a_rd_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
	!(ddr_rd && ddr_we))
	else $error("ddr_rd and ddr_we high together");

a_strobe_hold: assert property (@(posedge clk) disable iff (!rst_n)
	ddr_busy |=> $stable({ddr_rd, ddr_we}))
	else $error("command strobe changed under ddr_busy");

// a presented command keeps its address, enables and write data
a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
	ddr_busy && (ddr_rd || ddr_we) |=>
	$stable({ddr_addr, ddr_be, ddr_burstcnt}) && (!ddr_we || $stable(ddr_din)))
	else $error("command payload changed under ddr_busy");

endmodule

`default_nettype wire

//--- hdl/port_line_cache.sv
// per-port line cache: read line, write-combining buffer, flush and refill bookkeeping
`timescale 1ns/1ps
`default_nettype none

module port_line_cache (
	input  logic                                   clk,
	input  logic                                   rst_n,
	// client port
	input  logic [ddr_cache_pkg::port_addr_w:1]    addr,
	input  logic [ddr_cache_pkg::port_data_w-1:0]  din,
	input  logic                                   rd,
	input  logic [ddr_cache_pkg::port_lane_w-1:0]  wr,
	input  logic                                   mode16,
	output logic [ddr_cache_pkg::port_data_w-1:0]  dout,
	output logic                                   busy,
	// scheduler side
	output logic                                   rd_pend,
	output logic [ddr_cache_pkg::tag_w-1:0]        rd_tag,
	output logic                                   wr_pend,
	output logic [ddr_bus_pkg::ddr_word_w-1:0]     wr_addr,
	output logic [ddr_bus_pkg::ddr_data_w-1:0]     wr_data,
	output logic [ddr_bus_pkg::ddr_be_w-1:0]       wr_be,
	input  logic                                   wr_done,
	input  logic                                   fill_valid,
	input  logic                                   fill_hi,
	input  logic [ddr_bus_pkg::ddr_data_w-1:0]     fill_data
);

localparam int dw  = ddr_cache_pkg::port_data_w;
localparam int lnw = ddr_cache_pkg::line_w;
localparam int lb  = ddr_cache_pkg::line_bytes;
localparam int tw  = ddr_cache_pkg::tag_w;
localparam int hw  = ddr_cache_pkg::half_sel_w;
localparam int ww  = ddr_cache_pkg::word_sel_w;
localparam int bdw = ddr_bus_pkg::ddr_data_w;
localparam int bbw = ddr_bus_pkg::ddr_be_w;

// request edges
logic old_rd;
logic old_wr;
logic rd_req;
logic wr_req;
logic [tw-1:0] req_tag;
logic [hw-1:0] req_half;
logic [ww-1:0] req_word;

// read line
logic rline_valid;
logic [tw-1:0] rline_tag;
logic [hw-1:0] rline_sel;
logic rline_mode16;
logic [lnw-1:0] rline_data;

// write-combining buffer, dirty while any enable is set
logic [tw-1:0] wbuf_tag;
logic [lb-1:0] wbuf_be;
logic [lnw-1:0] wbuf_data;

// line on its way to the DDR
logic [tw-1:0] save_tag;
logic [lb-1:0] save_be;
logic [lnw-1:0] save_data;
// bit 1 upper half still to send, bit 0 lower half
logic [1:0] wr_half;

logic [lb-1:0] ln_be;
logic [lnw-1:0] ln_data;
logic rline_hit;
logic wbuf_hit;
logic wbuf_dirty;
logic flush_req;
logic [hw-1:0] dout_half;

assign rd_req = rd && !old_rd;
assign wr_req = |wr && !old_wr;
assign req_tag = addr[ddr_cache_pkg::port_addr_w -: tw];
assign req_half = addr[hw:1];
assign req_word = addr[hw -: ww];

assign wbuf_dirty = |wbuf_be;
assign rline_hit = rline_valid && rline_tag == req_tag;
assign wbuf_hit = wbuf_dirty && wbuf_tag == req_tag;
// read of a buffered line that the read line does not hold yet
// or a write that leaves a dirty line
assign flush_req = (rd_req && wbuf_hit && !rline_hit) || (wr_req && !wbuf_hit && wbuf_dirty);

// client lanes moved to their place in the line
// halfword 0 sits at the top of the line
always_comb begin
	ln_be = '0;
	ln_data = '0;
	if (mode16) begin
		ln_be[1:0] = wr[1:0];
		ln_data[dw/2-1:0] = din[dw/2-1:0];
		ln_be = ln_be << {~req_half, 1'b0};
		ln_data = ln_data << {~req_half, 4'b0000};
	end else begin
		ln_be[ddr_cache_pkg::port_lane_w-1:0] = wr;
		ln_data[dw-1:0] = din;
		ln_be = ln_be << {~req_word, 2'b00};
		ln_data = ln_data << {~req_word, 5'b00000};
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		old_rd <= 1'b0;
		old_wr <= 1'b0;
		rline_valid <= 1'b0;
		wbuf_be <= '0;
		wr_half <= 2'b00;
		rd_pend <= 1'b0;
	end else begin
		old_rd <= rd;
		old_wr <= |wr;
		// upper half always acknowledged first
		if (wr_done) begin
			if (wr_half[1])
				wr_half[1] <= 1'b0;
			else
				wr_half[0] <= 1'b0;
		end
		if (fill_valid && !fill_hi)
			rd_pend <= 1'b0;
		if (rd_req) begin
			rline_valid <= 1'b1;
			if (!rline_hit)
				rd_pend <= 1'b1;
			if (wbuf_hit && !rline_hit)
				wbuf_be <= '0;
		end
		if (wr_req)
			wbuf_be <= wbuf_hit ? (wbuf_be | ln_be) : ln_be;
		// only halves with enables go out
		if (flush_req)
			wr_half <= {|wbuf_be[lb-1 -: bbw], |wbuf_be[bbw-1:0]};
	end
end

always_ff @(posedge clk) begin
	if (fill_valid) begin
		if (fill_hi)
			rline_data[lnw-1 -: bdw] <= fill_data;
		else
			rline_data[bdw-1:0] <= fill_data;
	end
	if (rd_req) begin
		rline_tag <= req_tag;
		rline_sel <= req_half;
		rline_mode16 <= mode16;
	end
	if (flush_req) begin
		save_tag <= wbuf_tag;
		save_be <= wbuf_be;
		save_data <= wbuf_data;
	end
	if (wr_req) begin
		if (!wbuf_hit)
			wbuf_tag <= req_tag;
		// a write into the read line shows up there at once
		for (int b = 0; b < lb; b++) begin
			if (ln_be[b]) begin
				wbuf_data[8*b +: 8] <= ln_data[8*b +: 8];
				if (rline_hit)
					rline_data[8*b +: 8] <= ln_data[8*b +: 8];
			end
		end
	end
end

// scheduler view, the half to send next
assign rd_tag = rline_tag;
assign wr_pend = |wr_half;
assign wr_addr = {save_tag, !wr_half[1]};
assign wr_data = wr_half[1] ? save_data[lnw-1 -: bdw] : save_data[bdw-1:0];
assign wr_be = wr_half[1] ? save_be[lb-1 -: bbw] : save_be[bbw-1:0];

assign busy = rd_pend | wr_pend;

// read data, zero-extended halfword in 16-bit mode
assign dout_half = ~rline_sel;
always_comb begin
	if (rline_mode16)
		dout = {{(dw/2){1'b0}}, rline_data[{dout_half, 4'b0000} +: dw/2]};
	else
		dout = rline_data[{dout_half[hw-1 -: ww], 5'b00000} +: dw];
end

// refill beats only for a read this port asked for
a_fill_needs_pend: assert property (@(posedge clk) disable iff (!rst_n)
	fill_valid |-> rd_pend)
	else $error("fill_valid without a pending read");

// a half is only queued when it carries enabled bytes
a_wr_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
	wr_pend |-> wr_be != '0)
	else $error("write half pending with no byte enables");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the DDR front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f ddr_port_mux.f --top-module ddr_port_mux_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vddr_port_mux_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0

//--- tests/ddr_mem_model.sv
// behavioural DDR slave: random busy, delayed two-beat reads, byte-enabled storage
`timescale 1ns/1ps
`default_nettype none

module ddr_mem_model (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 ddr_rd,
	input  logic                                 ddr_we,
	input  logic [ddr_bus_pkg::ddr_addr_w-1:0]   ddr_addr,
	input  logic [ddr_bus_pkg::ddr_data_w-1:0]   ddr_din,
	input  logic [ddr_bus_pkg::ddr_be_w-1:0]     ddr_be,
	input  logic [ddr_bus_pkg::ddr_burst_w-1:0]  ddr_burstcnt,
	output logic                                 ddr_busy,
	output logic [ddr_bus_pkg::ddr_data_w-1:0]   ddr_dout,
	output logic                                 ddr_dout_ready,
	output int                                   fault_cnt
);

localparam int ww = ddr_bus_pkg::ddr_word_w;

// written bytes by byte address
logic [7:0] mem [int];
// command seen under busy, must look the same next cycle
logic held;
logic [1:0] held_cmd;
logic [ddr_bus_pkg::ddr_addr_w-1:0] held_addr;
logic [ddr_bus_pkg::ddr_data_w-1:0] held_din;
logic [ddr_bus_pkg::ddr_be_w-1:0] held_be;
logic [ddr_bus_pkg::ddr_burst_w-1:0] held_burst;
logic [ww-1:0] rd_word;
int wait_cnt;
// 0 idle, 1 latency, 2 upper beat out, 3 lower beat out
int phase;

// unwritten bytes follow the address pattern
function automatic logic [63:0] word_data(input logic [ww-1:0] w);
	logic [63:0] v;
	int ba;
	v = '0;
	for (int b = 0; b < 8; b++) begin
		ba = int'({w, 3'(b)});
		v[8*b +: 8] = mem.exists(ba) ? mem[ba] : (8'(ba) ^ 8'ha5);
	end
	return v;
endfunction

always @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ddr_busy <= 1'b0;
		ddr_dout <= '0;
		ddr_dout_ready <= 1'b0;
		held <= 1'b0;
		phase <= 0;
		wait_cnt <= 0;
		fault_cnt <= 0;
	end else begin
		ddr_busy <= ($urandom % 4) == 0;
		if (held && ({ddr_rd, ddr_we} != held_cmd || ddr_addr != held_addr ||
			ddr_be != held_be || ddr_burstcnt != held_burst ||
			(ddr_we && ddr_din != held_din))) begin
			$display("DDR command changed while ddr_busy was high at %0t", $time);
			fault_cnt <= fault_cnt + 1;
		end
		held <= ddr_busy && (ddr_rd || ddr_we);
		held_cmd <= {ddr_rd, ddr_we};
		held_addr <= ddr_addr;
		held_din <= ddr_din;
		held_be <= ddr_be;
		held_burst <= ddr_burstcnt;
		// every taken command lands in the DDR region with its burst count
		if (!ddr_busy && (ddr_rd || ddr_we)) begin
			if (ddr_addr[ddr_bus_pkg::ddr_addr_w-1 -: 4] != 4'h3) begin
				$display("DDR command outside the 0x30000000 region at %0t", $time);
				fault_cnt <= fault_cnt + 1;
			end
			if (ddr_burstcnt != (ddr_rd ? 8'd2 : 8'd1)) begin
				$display("DDR command with burst count %0d at %0t", ddr_burstcnt, $time);
				fault_cnt <= fault_cnt + 1;
			end
		end
		// write taken on a non-busy cycle
		if (!ddr_busy && ddr_we) begin
			for (int b = 0; b < 8; b++) begin
				if (ddr_be[b])
					mem[int'({ddr_addr[ww-1:0], 3'(b)})] = ddr_din[8*b +: 8];
			end
		end
		if (!ddr_busy && ddr_rd) begin
			rd_word <= ddr_addr[ww-1:0];
			wait_cnt <= int'(1 + $urandom % 6);
			phase <= 1;
		end
		// each beat stays until a non-busy edge takes it
		case (phase)
			1: begin
				if (wait_cnt == 1) begin
					ddr_dout <= word_data(rd_word);
					ddr_dout_ready <= 1'b1;
					phase <= 2;
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
			2: begin
				if (!ddr_busy) begin
					ddr_dout <= word_data({rd_word[ww-1:1], 1'b1});
					phase <= 3;
				end
			end
			3: begin
				if (!ddr_busy) begin
					ddr_dout_ready <= 1'b0;
					phase <= 0;
				end
			end
			default: ;
		endcase
	end
end

endmodule

`default_nettype wire

//--- tests/ddr_port_mux_tb.sv
// testbench for the multi-port DDR front end: table-driven client accesses on a DDR model
`timescale 1ns/1ps
`default_nettype none

module ddr_port_mux_tb;

localparam int np = 3;
localparam int timeout = 300;
localparam int op_rd = 0;
localparam int op_wr = 1;
// read on ports 0 and 2 in the same cycle
localparam int op_pair = 2;

typedef struct {
	int port;
	int op;
	bit m16;
	logic [26:0] a;
	logic [31:0] data;
	logic [3:0] lanes;
	bit hit;
} step_t;

logic clk;
logic rst_n;
logic [ddr_cache_pkg::port_addr_w:1] addr [np];
logic [ddr_cache_pkg::port_data_w-1:0] din [np];
logic [np-1:0] rd;
logic [ddr_cache_pkg::port_lane_w-1:0] wr [np];
logic [np-1:0] mode16;
logic [ddr_cache_pkg::port_data_w-1:0] dout [np];
logic [np-1:0] busy;
logic ddr_busy;
logic [ddr_bus_pkg::ddr_data_w-1:0] ddr_dout;
logic ddr_dout_ready;
logic ddr_rd;
logic ddr_we;
logic [ddr_bus_pkg::ddr_addr_w-1:0] ddr_addr;
logic [ddr_bus_pkg::ddr_data_w-1:0] ddr_din;
logic [ddr_bus_pkg::ddr_be_w-1:0] ddr_be;
logic [ddr_bus_pkg::ddr_burst_w-1:0] ddr_burstcnt;
int fault_cnt;

step_t steps[$];
// bytes written by the clients, by DDR byte address
logic [7:0] shadow [int];
int pass_cnt;
int fail_cnt;

ddr_port_mux #(.num_ports(np)) ddr_port_mux_inst (
	.clk(clk), .rst_n(rst_n), .addr(addr), .din(din), .rd(rd), .wr(wr),
	.mode16(mode16), .dout(dout), .busy(busy), .ddr_busy(ddr_busy),
	.ddr_dout(ddr_dout), .ddr_dout_ready(ddr_dout_ready), .ddr_rd(ddr_rd),
	.ddr_we(ddr_we), .ddr_addr(ddr_addr), .ddr_din(ddr_din), .ddr_be(ddr_be),
	.ddr_burstcnt(ddr_burstcnt)
);

ddr_mem_model ddr_mem_model_inst (
	.clk(clk), .rst_n(rst_n), .ddr_rd(ddr_rd), .ddr_we(ddr_we), .ddr_addr(ddr_addr),
	.ddr_din(ddr_din), .ddr_be(ddr_be), .ddr_burstcnt(ddr_burstcnt),
	.ddr_busy(ddr_busy), .ddr_dout(ddr_dout), .ddr_dout_ready(ddr_dout_ready),
	.fault_cnt(fault_cnt)
);

always #5 clk = ~clk;

function automatic logic [26:0] line_addr(input logic [23:0] tag, input logic [2:0] h);
	return {tag, h};
endfunction

// line byte 15 is the top of the line, the upper DDR word comes first
function automatic int byte_addr(input logic [26:0] a, input int lb);
	return int'(a[26:3]) * 16 + (lb ^ 8);
endfunction

function automatic logic [7:0] mem_byte(input int ba);
	if (shadow.exists(ba))
		return shadow[ba];
	return 8'(ba) ^ 8'ha5;
endfunction

// lowest line byte of the word or halfword, index 0 sits at the top
function automatic int lane_base(input logic [26:0] a, input bit m16);
	if (m16)
		return (7 - int'(a[2:0])) * 2;
	return (3 - int'(a[2:1])) * 4;
endfunction

function automatic logic [31:0] expect_read(input logic [26:0] a, input bit m16);
	logic [31:0] v;
	int lb;
	v = '0;
	lb = lane_base(a, m16);
	for (int k = 0; k < (m16 ? 2 : 4); k++)
		v[8*k +: 8] = mem_byte(byte_addr(a, lb + k));
	return v;
endfunction

task record_write(input step_t s);
	int lb;
	lb = lane_base(s.a, s.m16);
	for (int k = 0; k < (s.m16 ? 2 : 4); k++) begin
		if (s.lanes[k])
			shadow[byte_addr(s.a, lb + k)] = s.data[8*k +: 8];
	end
endtask

task add_step(input int port, input int op, input bit m16, input logic [26:0] a,
	input logic [31:0] data, input logic [3:0] lanes, input bit hit);
	step_t s;
	s = '{port, op, m16, a, data, lanes, hit};
	steps.push_back(s);
endtask

task drive_request(input int p, input step_t s);
	addr[p] <= s.a;
	din[p] <= s.data;
	mode16[p] <= s.m16;
	if (s.op == op_wr)
		wr[p] <= s.lanes;
	else
		rd[p] <= 1'b1;
endtask

task compare_dout(input int p, input logic [31:0] exp, inout bit ok);
	if (dout[p] !== exp) begin
		$display("ERR dout[%0d] got %h expected %h", p, dout[p], exp);
		ok = 0;
	end
endtask

task run_step(input step_t s, input int n);
	bit ok;
	int cyc;
	int f0;
	int f2;
	ok = 1;
	cyc = 0;
	f0 = -1;
	f2 = -1;
	@(posedge clk);
	if (s.op == op_pair) begin
		drive_request(0, s);
		drive_request(2, s);
	end else begin
		drive_request(s.port, s);
	end
	@(posedge clk);
	rd <= '0;
	wr[s.port] <= '0;
	if (s.op == op_pair) begin
		while ((f0 < 0 || f2 < 0) && cyc < timeout) begin
			@(negedge clk);
			if (f0 < 0 && !busy[0])
				f0 = cyc;
			if (f2 < 0 && !busy[2])
				f2 = cyc;
			cyc++;
		end
		if (f0 < 0 || f2 < 0) begin
			$display("ports 0 and 2 still busy after %0d cycles", timeout);
			ok = 0;
		end else if (f0 > f2) begin
			$display("port 0 was served after port 2");
			ok = 0;
		end
		compare_dout(0, expect_read(s.a, s.m16), ok);
		compare_dout(2, expect_read(s.a, s.m16), ok);
	end else begin
		@(negedge clk);
		while (busy[s.port] && cyc < timeout) begin
			@(negedge clk);
			cyc++;
		end
		if (busy[s.port]) begin
			$display("port %0d still busy after %0d cycles", s.port, timeout);
			ok = 0;
		end
		// a hit keeps busy low for two more cycles
		if (s.hit) begin
			if (cyc != 0) begin
				$display("port %0d went busy on a hit", s.port);
				ok = 0;
			end
			for (int i = 0; i < 3; i++) begin
				if (i > 0)
					@(negedge clk);
				if (busy[s.port] !== 1'b0) begin
					$display("ERR busy[%0d] got %h expected %h", s.port, busy[s.port], 1'b0);
					ok = 0;
				end
			end
		end
		if (s.op == op_wr)
			record_write(s);
		else
			compare_dout(s.port, expect_read(s.a, s.m16), ok);
	end
	$display("test %0d port %0d op %0d addr %h: %s", n, s.port, s.op, s.a,
		ok ? "ok" : "wrong");
	if (ok)
		pass_cnt++;
	else
		fail_cnt++;
endtask

initial begin
	void'($urandom(32'hc05c7952));
	clk = 1'b0;
	pass_cnt = 0;
	fail_cnt = 0;
	rst_n <= 1'b0;
	rd <= '0;
	mode16 <= '0;
	for (int p = 0; p < np; p++) begin
		addr[p] <= '0;
		din[p] <= '0;
		wr[p] <= '0;
	end
	// miss then hit, then halfword reads
	add_step(0, op_rd, 0, line_addr(24'h000100, 3'd2), '0, '0, 0);
	add_step(0, op_rd, 0, line_addr(24'h000100, 3'd6), '0, '0, 1);
	add_step(1, op_rd, 1, line_addr(24'h000200, 3'd0), '0, '0, 0);
	add_step(1, op_rd, 1, line_addr(24'h000200, 3'd3), '0, '0, 1);
	add_step(1, op_rd, 1, line_addr(24'h000200, 3'd6), '0, '0, 1);
	add_step(1, op_rd, 1, line_addr(24'h000200, 3'd7), '0, '0, 1);
	// combining on port 0, flushed by a write to another line
	add_step(0, op_wr, 0, line_addr(24'h000300, 3'd0), 32'h11223344, 4'b0101, 0);
	add_step(0, op_wr, 1, line_addr(24'h000300, 3'd5), 32'h0000beef, 4'b0010, 0);
	add_step(0, op_wr, 0, line_addr(24'h000400, 3'd4), 32'hcafef00d, 4'b1111, 0);
	add_step(1, op_rd, 0, line_addr(24'h000300, 3'd0), '0, '0, 0);
	add_step(1, op_rd, 1, line_addr(24'h000300, 3'd5), '0, '0, 1);
	// read-after-write on port 0
	add_step(0, op_wr, 0, line_addr(24'h000100, 3'd2), 32'h5a5a1234, 4'b1111, 0);
	add_step(0, op_rd, 0, line_addr(24'h000100, 3'd2), '0, '0, 1);
	add_step(0, op_rd, 0, line_addr(24'h000500, 3'd0), '0, '0, 0);
	add_step(0, op_rd, 0, line_addr(24'h000100, 3'd2), '0, '0, 0);
	// ports 0 and 2 together, then the flushed line from port 1
	add_step(0, op_pair, 0, line_addr(24'h000400, 3'd4), '0, '0, 0);
	add_step(1, op_rd, 0, line_addr(24'h000100, 3'd2), '0, '0, 0);
	repeat (4) @(posedge clk);
	rst_n <= 1'b1;
	repeat (2) @(posedge clk);
	for (int n = 0; n < steps.size(); n++)
		run_step(steps[n], n);
	repeat (4) @(posedge clk);
	$display("checks passed %0d wrong %0d bus faults %0d", pass_cnt, fail_cnt, fault_cnt);
	if (fail_cnt == 0 && fault_cnt == 0) begin
		$display("All tests passed");
	end else begin
		$display("Some tests failed");
	end
	$finish;
end

endmodule

`default_nettype wire
